/* verilog/isaPkg.sv */
package isaPkg;

   // Data and instruction words share one width
   typedef logic [15:0] word_t;
   typedef logic [2:0]  regIdx_t;

   // Instruction fields
   typedef logic [1:0]  funct_t;
   typedef logic [4:0]  imm5_t;
   typedef logic [7:0]  imm8_t;
   typedef logic [10:0] imm11_t;

   // Major opcodes in instr[15:11]; any other code is illegal
   typedef enum logic [4:0] {
      opHalt  = 5'b00000,
      opNop   = 5'b00001,
      opJ     = 5'b00100,
      opAddi  = 5'b01000,
      opSubi  = 5'b01001,
      opXori  = 5'b01010,
      opAndni = 5'b01011,
      opBeqz  = 5'b01100,
      opBnez  = 5'b01101,
      opSt    = 5'b10000,
      opLd    = 5'b10001,
      opSlbi  = 5'b10010,
      opStu   = 5'b10011,
      opLbi   = 5'b11000,
      opRType = 5'b11011
   } opcode_t;

   // R-type function codes in instr[1:0]
   localparam funct_t functAdd  = 2'b00;
   localparam funct_t functSub  = 2'b01;
   localparam funct_t functXor  = 2'b10;
   localparam funct_t functAndn = 2'b11;

endpackage

/* verilog/ctrlPkg.sv */
package ctrlPkg;

   // Sub is operand B minus operand A
   typedef enum logic [2:0] {
      aluAdd,
      aluSub,
      aluXor,
      aluAndn,
      aluPassB,
      aluShiftLoad
   } aluOp_t;

   typedef enum logic [2:0] {
      immSign5,
      immZero5,
      immSign8,
      immZero8,
      immSign11
   } immKind_t;

   typedef enum logic [1:0] {
      wbAlu,
      wbMem,
      wbImm
   } wbSrc_t;

   typedef enum logic [1:0] {
      brNone,
      brEqz,
      brNez
   } branchCond_t;

   // Destination field: rs (LBI, SLBI, STU), rt (I-format), rd (R-format)
   typedef enum logic [1:0] {
      destRs,
      destRt,
      destRd
   } destSel_t;

endpackage

/* verilog/ctrlIf.sv */
interface ctrlIf
   import ctrlPkg::*;
();

   logic        regWrite;
   destSel_t    destSel;
   immKind_t    immKind;
   logic        aluSrcImm;
   aluOp_t      aluOp;
   logic        memRead;
   logic        memWrite;
   wbSrc_t      wbSrc;
   branchCond_t branchCond;
   logic        jump;
   logic        halt;
   logic        illegal;

   modport ctrl (
      output regWrite, destSel, immKind, aluSrcImm, aluOp, memRead, memWrite,
      output wbSrc, branchCond, jump, halt, illegal
   );

   modport fetchSide (input halt);

   modport decodeSide (input regWrite, destSel, immKind);

   // Memory strobes let execute tell address arithmetic from ADD/SUB
   modport execSide (input aluSrcImm, aluOp, branchCond, jump, memRead, memWrite);

   modport memSide (input memRead, memWrite, wbSrc);

endinterface

/* verilog/fetch.sv */
module fetch
   import isaPkg::*;
#(
   parameter int memAddrWidth = 8
) (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    imemWe,
   input  logic [memAddrWidth-1:0] imemWa,
   input  word_t                   imemWd,
   input  word_t                   nextPc,
   ctrlIf.fetchSide                ctl,
   output word_t                   instr,
   output word_t                   pcPlus1
);

   word_t pc;
   word_t imem [2**memAddrWidth];

   // Loader port only works while the core is held in reset
   always_ff @(posedge clk)
   begin
      if (rst && imemWe)
      begin
         imem[imemWa] <= imemWd;
      end
   end

   // PC freezes on HALT so the halt instruction stays fetched
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pc <= '0;
      end
      else if (!ctl.halt)
      begin
         pc <= nextPc;
      end
   end

   // Word addressed, upper PC bits ignored
   assign instr   = imem[pc[memAddrWidth-1:0]];
   assign pcPlus1 = pc + word_t'(1);

endmodule

/* verilog/control.sv */
module control
   import isaPkg::*;
   import ctrlPkg::*;
(
   input  word_t instr,
   ctrlIf.ctrl   ctl
);

   opcode_t op;
   funct_t  funct;

   assign op    = opcode_t'(instr[15:11]);
   assign funct = instr[1:0];

   always_comb
   begin
      // Defaults describe a NOP
      ctl.regWrite   = 1'b0;
      ctl.destSel    = destRt;
      ctl.immKind    = immSign5;
      ctl.aluSrcImm  = 1'b0;
      ctl.aluOp      = aluPassB;
      ctl.memRead    = 1'b0;
      ctl.memWrite   = 1'b0;
      ctl.wbSrc      = wbAlu;
      ctl.branchCond = brNone;
      ctl.jump       = 1'b0;
      ctl.halt       = 1'b0;
      ctl.illegal    = 1'b0;

      case (op)
         opHalt:
         begin
            ctl.halt = 1'b1;
         end
         opNop:
         begin
            ctl.halt = 1'b0;
         end
         opAddi, opSubi, opXori, opAndni:
         begin
            ctl.regWrite  = 1'b1;
            ctl.aluSrcImm = 1'b1;
            // Logical immediates are zero extended
            ctl.immKind = (op == opXori || op == opAndni) ? immZero5 : immSign5;
            case (op)
               opSubi:  ctl.aluOp = aluSub;
               opXori:  ctl.aluOp = aluXor;
               opAndni: ctl.aluOp = aluAndn;
               default: ctl.aluOp = aluAdd;
            endcase
         end
         opRType:
         begin
            ctl.regWrite = 1'b1;
            ctl.destSel  = destRd;
            case (funct)
               functSub:  ctl.aluOp = aluSub;
               functXor:  ctl.aluOp = aluXor;
               functAndn: ctl.aluOp = aluAndn;
               default:   ctl.aluOp = aluAdd;
            endcase
         end
         opLbi:
         begin
            ctl.regWrite = 1'b1;
            ctl.destSel  = destRs;
            ctl.immKind  = immSign8;
            ctl.wbSrc    = wbImm;
         end
         opSlbi:
         begin
            ctl.regWrite  = 1'b1;
            ctl.destSel   = destRs;
            ctl.immKind   = immZero8;
            ctl.aluSrcImm = 1'b1;
            ctl.aluOp     = aluShiftLoad;
         end
         opLd:
         begin
            ctl.regWrite  = 1'b1;
            ctl.aluSrcImm = 1'b1;
            ctl.aluOp     = aluAdd;
            ctl.memRead   = 1'b1;
            ctl.wbSrc     = wbMem;
         end
         opSt, opStu:
         begin
            ctl.aluSrcImm = 1'b1;
            ctl.aluOp     = aluAdd;
            ctl.memWrite  = 1'b1;
            // STU also writes the effective address back to rs
            if (op == opStu)
            begin
               ctl.regWrite = 1'b1;
               ctl.destSel  = destRs;
            end
         end
         opBeqz, opBnez:
         begin
            ctl.immKind    = immSign8;
            ctl.branchCond = (op == opBeqz) ? brEqz : brNez;
         end
         opJ:
         begin
            ctl.immKind = immSign11;
            ctl.jump    = 1'b1;
         end
         default:
         begin
            ctl.illegal = 1'b1;
         end
      endcase
   end

endmodule

/* verilog/decode.sv */
module decode
   import isaPkg::*;
   import ctrlPkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  word_t     instr,
   input  word_t     wbData,
   ctrlIf.decodeSide ctl,
   output word_t     rsData,
   output word_t     rtData,
   output word_t     immExt,
   output logic      regWe,
   output regIdx_t   regWa,
   output word_t     regWd
);

   word_t   regs [8];
   regIdx_t rsIdx;
   regIdx_t rtIdx;
   regIdx_t rdIdx;
   imm5_t   imm5;
   imm8_t   imm8;
   imm11_t  imm11;

   assign rsIdx = instr[10:8];
   assign rtIdx = instr[7:5];
   assign rdIdx = instr[4:2];
   assign imm5  = instr[4:0];
   assign imm8  = instr[7:0];
   assign imm11 = instr[10:0];

   assign rsData = regs[rsIdx];
   assign rtData = regs[rtIdx];

   always_comb
   begin
      case (ctl.immKind)
         immSign5:  immExt = {{11{imm5[4]}}, imm5};
         immZero5:  immExt = {11'b0, imm5};
         immSign8:  immExt = {{8{imm8[7]}}, imm8};
         immZero8:  immExt = {8'b0, imm8};
         immSign11: immExt = {{5{imm11[10]}}, imm11};
         default:   immExt = '0;
      endcase
   end

   always_comb
   begin
      case (ctl.destSel)
         destRs:  regWa = rsIdx;
         destRd:  regWa = rdIdx;
         default: regWa = rtIdx;
      endcase
   end

   // A write during reset never lands, so the trace shows none
   assign regWe = ctl.regWrite && !rst;
   assign regWd = wbData;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < 8; i++)
         begin
            regs[i] <= '0;
         end
      end
      else if (regWe)
      begin
         regs[regWa] <= regWd;
      end
   end

endmodule

/* verilog/execute.sv */
module execute
   import isaPkg::*;
   import ctrlPkg::*;
(
   input  word_t   rsData,
   input  word_t   rtData,
   input  word_t   immExt,
   input  word_t   pcPlus1,
   ctrlIf.execSide ctl,
   output word_t   aluOut,
   output word_t   storeData,
   output word_t   nextPc,
   output logic    overflow
);

   word_t opA;
   word_t opB;
   logic  arithOvf;
   logic  taken;
   word_t target;

   assign opA = rsData;
   assign opB = ctl.aluSrcImm ? immExt : rtData;

   always_comb
   begin
      aluOut   = '0;
      arithOvf = 1'b0;
      case (ctl.aluOp)
         aluAdd:
         begin
            aluOut   = opA + opB;
            arithOvf = (opA[15] == opB[15]) && (aluOut[15] != opA[15]);
         end
         aluSub:
         begin
            // B minus A, overflow when signs differ and result flips from B
            aluOut   = opB - opA;
            arithOvf = (opA[15] != opB[15]) && (aluOut[15] != opB[15]);
         end
         aluXor:       aluOut = opA ^ opB;
         aluAndn:      aluOut = opA & ~opB;
         aluPassB:     aluOut = opB;
         aluShiftLoad: aluOut = {opA[7:0], 8'h00} | opB;
         default:      aluOut = '0;
      endcase
   end

   // Address adds for LD, ST and STU never flag err
   assign overflow = arithOvf && !ctl.memRead && !ctl.memWrite;

   // ST and STU store rt; the rs update for STU comes from aluOut
   assign storeData = rtData;

   always_comb
   begin
      case (ctl.branchCond)
         brEqz:   taken = (rsData == '0);
         brNez:   taken = (rsData != '0);
         default: taken = 1'b0;
      endcase
   end

   // Branch and J offsets are relative to the following word
   assign target = pcPlus1 + immExt;
   assign nextPc = (taken || ctl.jump) ? target : pcPlus1;

endmodule

/* verilog/memory.sv */
module memory
   import isaPkg::*;
   import ctrlPkg::*;
#(
   parameter int memAddrWidth = 8
) (
   input  logic   clk,
   input  logic   rst,
   input  word_t  aluOut,
   input  word_t  storeData,
   input  word_t  immExt,
   ctrlIf.memSide ctl,
   output word_t  wbData
);

   word_t                   dmem [2**memAddrWidth];
   logic [memAddrWidth-1:0] addr;
   word_t                   readData;

   assign addr = aluOut[memAddrWidth-1:0];

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < 2**memAddrWidth; i++)
         begin
            dmem[i] <= '0;
         end
      end
      else if (ctl.memWrite)
      begin
         dmem[addr] <= storeData;
      end
   end

   // Asynchronous read
   assign readData = ctl.memRead ? dmem[addr] : '0;

   always_comb
   begin
      case (ctl.wbSrc)
         wbMem:   wbData = readData;
         wbImm:   wbData = immExt;
         default: wbData = aluOut;
      endcase
   end

endmodule

/* verilog/proc.sv */
module proc
   import isaPkg::*;
#(
   parameter int memAddrWidth = 8
) (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    imemWe,
   input  logic [memAddrWidth-1:0] imemWa,
   input  word_t                   imemWd,
   output logic                    regWe,
   output regIdx_t                 regWa,
   output word_t                   regWd,
   output logic                    halted,
   output logic                    err
);

   word_t instr;
   word_t pcPlus1;
   word_t nextPc;
   word_t rsData;
   word_t rtData;
   word_t immExt;
   word_t aluOut;
   word_t storeData;
   word_t wbData;
   logic  overflow;

   ctrlIf ctlBus ();

   fetch #(
      .memAddrWidth(memAddrWidth)
   ) fetchInst (
      .clk    (clk),
      .rst    (rst),
      .imemWe (imemWe),
      .imemWa (imemWa),
      .imemWd (imemWd),
      .nextPc (nextPc),
      .ctl    (ctlBus.fetchSide),
      .instr  (instr),
      .pcPlus1(pcPlus1)
   );

   control controlInst (
      .instr(instr),
      .ctl  (ctlBus.ctrl)
   );

   decode decodeInst (
      .clk   (clk),
      .rst   (rst),
      .instr (instr),
      .wbData(wbData),
      .ctl   (ctlBus.decodeSide),
      .rsData(rsData),
      .rtData(rtData),
      .immExt(immExt),
      .regWe (regWe),
      .regWa (regWa),
      .regWd (regWd)
   );

   execute executeInst (
      .rsData   (rsData),
      .rtData   (rtData),
      .immExt   (immExt),
      .pcPlus1  (pcPlus1),
      .ctl      (ctlBus.execSide),
      .aluOut   (aluOut),
      .storeData(storeData),
      .nextPc   (nextPc),
      .overflow (overflow)
   );

   memory #(
      .memAddrWidth(memAddrWidth)
   ) memoryInst (
      .clk      (clk),
      .rst      (rst),
      .aluOut   (aluOut),
      .storeData(storeData),
      .immExt   (immExt),
      .ctl      (ctlBus.memSide),
      .wbData   (wbData)
   );

   assign halted = ctlBus.halt;
   assign err    = ctlBus.illegal | overflow;

endmodule

/* test/clkGen.sv */
module clkGen
(
   input  logic hold,
   output logic clk,
   output logic rst
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam int resetCycles = 4;

   int count;

   initial
   begin
      clk   = 1'b0;
      rst   = 1'b1;
      count = 0;
   end

   // 4 ns period
   always #2 clk = ~clk;

   // Reset stays up while the program loads, then four more cycles
   always @(posedge clk)
   begin
      if (hold)
      begin
         count <= 0;
         rst   <= 1'b1;
      end
      else if (count < resetCycles)
      begin
         count <= count + 1;
         rst   <= 1'b1;
      end
      else
      begin
         rst <= 1'b0;
      end
   end

endmodule

/* test/proc_assert.sv */
module procAssert
(
   input logic clk,
   input logic rst,
   input logic regWe,
   input logic halted
);
   timeunit 1ns;
   timeprecision 100ps;

   // Read by the testbench at the end of the run
   int failCount = 0;

   // A halted core commits nothing
   noWriteWhileHalted: assert property (@(posedge clk) disable iff (rst) halted |-> !regWe)
   else
   begin
      failCount++;
      $error("regWe high while halted");
   end

   noWriteInReset: assert property (@(posedge clk) rst |-> !regWe)
   else
   begin
      failCount++;
      $error("regWe high during reset");
   end

   // PC holds on HALT, so halted never drops again
   haltSticky: assert property (@(posedge clk) disable iff (rst) halted |=> halted)
   else
   begin
      failCount++;
      $error("halted dropped after rising");
   end

endmodule

bind proc procAssert procAssertInst (
   .clk   (clk),
   .rst   (rst),
   .regWe (regWe),
   .halted(halted)
);

/* test/procTb.sv */
module procTb
   import isaPkg::*;
;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int addrWidth  = 8;
   localparam int progLen    = 38;
   localparam int maxSteps   = progLen;
   localparam int idleCycles = 8;
   localparam int clkPeriod  = 4;
   // Loading takes one cycle per word; forward-only branches bound the run by progLen
   localparam int watchCycles = progLen + progLen + 20;

   logic                 clk;
   logic                 rst;
   logic                 hold;
   logic                 imemWe;
   logic [addrWidth-1:0] imemWa;
   word_t                imemWd;
   logic                 regWe;
   regIdx_t              regWa;
   word_t                regWd;
   logic                 halted;
   logic                 err;

   word_t       image [progLen];
   logic        expWe [maxSteps];
   regIdx_t     expIdx [maxSteps];
   word_t       expVal [maxSteps];
   logic        expErr [maxSteps];
   int          haltStep;
   integer      seed;
   logic [31:0] rnd;

   clkGen clkGenInst (
      .hold(hold),
      .clk (clk),
      .rst (rst)
   );

   proc #(
      .memAddrWidth(addrWidth)
   ) proc_inst (
      .clk   (clk),
      .rst   (rst),
      .imemWe(imemWe),
      .imemWa(imemWa),
      .imemWd(imemWd),
      .regWe (regWe),
      .regWa (regWa),
      .regWd (regWd),
      .halted(halted),
      .err   (err)
   );

   task automatic failRun(string why);
      $display("%s", why);
      $display("SIMULATION FAILED");
      $fatal(1);
   endtask

   task automatic checkIdx(string name, int step, regIdx_t got, regIdx_t exp);
      if (got !== exp)
      begin
         failRun($sformatf("Mismatch %s at step %0d: got 0x%h, expected 0x%h",
                           name, step, got, exp));
      end
   endtask

   task automatic checkWord(string name, int step, word_t got, word_t exp);
      if (got !== exp)
      begin
         failRun($sformatf("Mismatch %s at step %0d: got 0x%h, expected 0x%h",
                           name, step, got, exp));
      end
   endtask

   task automatic checkFlag(string name, int step, logic got, logic exp);
      if (got !== exp)
      begin
         failRun($sformatf("Mismatch %s at step %0d: got 0x%h, expected 0x%h",
                           name, step, got, exp));
      end
   endtask

   function imm8_t randomByte();
      rnd = $random(seed);
      return rnd[7:0];
   endfunction

   function imm5_t randomImm5();
      rnd = $random(seed);
      return rnd[4:0];
   endfunction

   // I-format: rt gets rs op imm
   function automatic word_t encodeImm(opcode_t op, regIdx_t rs, regIdx_t rt, imm5_t imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic word_t encodeReg(regIdx_t rs, regIdx_t rt, regIdx_t rd, funct_t fn);
      return {opRType, rs, rt, rd, fn};
   endfunction

   function automatic word_t encodeByte(opcode_t op, regIdx_t rs, imm8_t imm);
      return {op, rs, imm};
   endfunction

   function automatic word_t encodeJump(imm11_t imm);
      return {opJ, imm};
   endfunction

   function void buildImage();
      // Random register seeds
      image[0]  = encodeByte(opLbi, 3'd1, randomByte());
      image[1]  = encodeByte(opLbi, 3'd2, randomByte());
      image[2]  = encodeByte(opLbi, 3'd3, randomByte());
      image[3]  = encodeByte(opSlbi, 3'd3, randomByte());
      image[4]  = encodeImm(opAddi, 3'd1, 3'd4, randomImm5());
      image[5]  = encodeImm(opSubi, 3'd2, 3'd5, randomImm5());
      image[6]  = encodeImm(opXori, 3'd3, 3'd6, randomImm5());
      image[7]  = encodeImm(opAndni, 3'd3, 3'd7, randomImm5());
      image[8]  = encodeReg(3'd1, 3'd2, 3'd4, functAdd);
      image[9]  = encodeReg(3'd1, 3'd3, 3'd5, functSub);
      image[10] = encodeReg(3'd2, 3'd3, 3'd6, functXor);
      image[11] = encodeReg(3'd2, 3'd3, 3'd7, functAndn);
      // 0x7fff in r1, then forced overflows
      image[12] = encodeByte(opLbi, 3'd1, 8'h7f);
      image[13] = encodeByte(opSlbi, 3'd1, 8'hff);
      image[14] = encodeImm(opAddi, 3'd1, 3'd2, 5'd1);
      image[15] = encodeReg(3'd1, 3'd1, 3'd3, functAdd);
      image[16] = encodeByte(opLbi, 3'd4, 8'h80);
      image[17] = encodeReg(3'd1, 3'd4, 3'd5, functSub);
      image[18] = encodeImm(opSubi, 3'd4, 3'd6, 5'd1);
      // Memory traffic around base 0x10
      image[19] = encodeByte(opLbi, 3'd1, 8'h10);
      image[20] = encodeImm(opSt, 3'd1, 3'd7, 5'd2);
      image[21] = encodeImm(opLd, 3'd1, 3'd2, 5'd2);
      image[22] = encodeImm(opStu, 3'd1, 3'd3, 5'h1d);
      image[23] = encodeImm(opLd, 3'd1, 3'd4, 5'd0);
      // Branches only go forward
      image[24] = encodeByte(opLbi, 3'd5, 8'h00);
      image[25] = encodeByte(opBeqz, 3'd5, 8'd2);
      image[26] = encodeImm(opAddi, 3'd6, 3'd6, 5'd1);
      image[27] = encodeImm(opAddi, 3'd6, 3'd6, 5'd1);
      image[28] = encodeByte(opBnez, 3'd5, 8'd1);
      image[29] = encodeByte(opBnez, 3'd4, 8'd1);
      image[30] = encodeImm(opXori, 3'd7, 3'd7, 5'd5);
      image[31] = encodeJump(11'd2);
      image[32] = encodeByte(opLbi, 3'd7, 8'h01);
      image[33] = encodeByte(opLbi, 3'd7, 8'h02);
      // Unlisted opcode
      image[34] = {5'b11111, randomByte(), 3'b000};
      image[35] = {opNop, 11'd0};
      image[36] = {opHalt, 11'd0};
      image[37] = encodeByte(opLbi, 3'd1, 8'h55);
   endfunction

   // ISA model; returns the step of the HALT, or -1 if it leaves the image
   function automatic int runModel();
      word_t   regs [8];
      word_t   dmem [2**addrWidth];
      word_t   pc;
      word_t   instr;
      word_t   a;
      word_t   b;
      word_t   s5;
      word_t   z5;
      word_t   s8;
      word_t   z8;
      word_t   s11;
      word_t   val;
      regIdx_t rs;
      regIdx_t rt;
      regIdx_t dest;
      logic    we;
      logic    ovf;
      int      wide;

      foreach (regs[i])
      begin
         regs[i] = '0;
      end
      foreach (dmem[i])
      begin
         dmem[i] = '0;
      end
      pc = '0;
      for (int step = 0; step < maxSteps; step++)
      begin
         if (pc >= progLen)
         begin
            return -1;
         end
         instr = image[pc];
         rs    = instr[10:8];
         rt    = instr[7:5];
         a     = regs[rs];
         b     = regs[rt];
         s5    = {{11{instr[4]}}, instr[4:0]};
         z5    = {11'b0, instr[4:0]};
         s8    = {{8{instr[7]}}, instr[7:0]};
         z8    = {8'b0, instr[7:0]};
         s11   = {{5{instr[10]}}, instr[10:0]};
         we    = 1'b0;
         ovf   = 1'b0;
         dest  = rt;
         val   = '0;
         wide  = 0;
         pc    = pc + 16'd1;
         case (instr[15:11])
            opHalt:
            begin
               expWe[step]  = 1'b0;
               expErr[step] = 1'b0;
               return step;
            end
            opNop:
            begin
               we = 1'b0;
            end
            opAddi:
            begin
               wide = int'($signed(a)) + int'($signed(s5));
               ovf  = (wide > 32767) || (wide < -32768);
               val  = word_t'(wide);
               we   = 1'b1;
            end
            opSubi:
            begin
               wide = int'($signed(s5)) - int'($signed(a));
               ovf  = (wide > 32767) || (wide < -32768);
               val  = word_t'(wide);
               we   = 1'b1;
            end
            opXori:
            begin
               val = a ^ z5;
               we  = 1'b1;
            end
            opAndni:
            begin
               val = a & ~z5;
               we  = 1'b1;
            end
            opRType:
            begin
               dest = instr[4:2];
               we   = 1'b1;
               case (instr[1:0])
                  functAdd:  wide = int'($signed(a)) + int'($signed(b));
                  functSub:  wide = int'($signed(b)) - int'($signed(a));
                  functXor:  val = a ^ b;
                  default:   val = a & ~b;
               endcase
               if (instr[1:0] == functAdd || instr[1:0] == functSub)
               begin
                  ovf = (wide > 32767) || (wide < -32768);
                  val = word_t'(wide);
               end
            end
            opLbi:
            begin
               dest = rs;
               val  = s8;
               we   = 1'b1;
            end
            opSlbi:
            begin
               dest = rs;
               val  = (a << 8) | z8;
               we   = 1'b1;
            end
            opLd:
            begin
               val = dmem[addrWidth'(a + s5)];
               we  = 1'b1;
            end
            opSt:
            begin
               dmem[addrWidth'(a + s5)] = b;
            end
            opStu:
            begin
               dmem[addrWidth'(a + s5)] = b;
               dest = rs;
               val  = a + s5;
               we   = 1'b1;
            end
            opBeqz:
            begin
               if (a == '0)
               begin
                  pc = pc + s8;
               end
            end
            opBnez:
            begin
               if (a != '0)
               begin
                  pc = pc + s8;
               end
            end
            opJ:
            begin
               pc = pc + s11;
            end
            default:
            begin
               // Illegal acts as NOP but flags err
               ovf = 1'b1;
            end
         endcase
         if (we)
         begin
            regs[dest] = val;
         end
         expWe[step]  = we;
         expIdx[step] = dest;
         expVal[step] = val;
         expErr[step] = ovf;
      end
      return -1;
   endfunction

   task automatic loadImage();
      for (int i = 0; i < progLen; i++)
      begin
         @(posedge clk);
         imemWe <= 1'b1;
         imemWa <= addrWidth'(i);
         imemWd <= image[i];
      end
      @(posedge clk);
      imemWe <= 1'b0;
      hold   <= 1'b0;
   endtask

   initial
   begin : stimulus
      hold   = 1'b1;
      imemWe = 1'b0;
      imemWa = '0;
      imemWd = '0;
      seed   = 32'hb3e6;
      buildImage();
      haltStep = runModel();
      if (haltStep < 0)
      begin
         failRun("Reference model ran past the program image without a HALT");
      end
      else
      begin
         loadImage();
      end
   end

   // Outputs are sampled mid-cycle, away from the driving edge
   initial
   begin : compare
      int step;

      @(negedge clk);
      while (rst)
      begin
         @(negedge clk);
      end
      for (step = 0; step <= haltStep; step++)
      begin
         if (step > 0)
         begin
            @(negedge clk);
         end
         checkFlag("err", step, err, expErr[step]);
         checkFlag("halted", step, halted, logic'(step == haltStep));
         checkFlag("regWe", step, regWe, expWe[step]);
         if (expWe[step])
         begin
            checkIdx("regWa", step, regWa, expIdx[step]);
            checkWord("regWd", step, regWd, expVal[step]);
         end
      end
      // Nothing commits after HALT
      for (int i = 0; i < idleCycles; i++)
      begin
         @(negedge clk);
         checkFlag("halted", haltStep + i + 1, halted, 1'b1);
         checkFlag("regWe", haltStep + i + 1, regWe, 1'b0);
      end
      if (proc_inst.procAssertInst.failCount != 0)
      begin
         failRun("Bound assertions reported failures");
      end
      else
      begin
         $display("SIMULATION PASSED");
         $finish;
      end
   end

   initial
   begin : assertWatch
      wait (proc_inst.procAssertInst.failCount != 0);
      failRun("A bound assertion failed");
   end

   initial
   begin : watchdog
      #(watchCycles * clkPeriod);
      failRun("Timeout: the run did not reach its end in time");
   end

endmodule

/* files.f */
verilog/isaPkg.sv
verilog/ctrlPkg.sv
verilog/ctrlIf.sv
verilog/fetch.sv
verilog/control.sv
verilog/decode.sv
verilog/execute.sv
verilog/memory.sv
verilog/proc.sv
test/clkGen.sv
test/proc_assert.sv
test/procTb.sv

/* Bender.yml */
package:
  name: proc

sources:
  - verilog/isaPkg.sv
  - verilog/ctrlPkg.sv
  - verilog/ctrlIf.sv
  - verilog/fetch.sv
  - verilog/control.sv
  - verilog/decode.sv
  - verilog/execute.sv
  - verilog/memory.sv
  - verilog/proc.sv
  - target: test
    files:
      - test/clkGen.sv
      - test/proc_assert.sv
      - test/procTb.sv
